// File: all.f
+incdir+design
+incdir+tb
design/cpu_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/mem_stage.sv
design/hazard_unit.sv
design/cpu_core.sv
tb/tb_cpu.sv

// File: design/cpu_core.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module cpu_core (
    input  logic             clk,
    input  logic             rst,
    output logic [`XLEN-1:0] imem_addr,
    input  logic [`XLEN-1:0] imem_rdata,
    input  logic             iready_n,
    output logic [`XLEN-1:0] dmem_addr,
    output logic [`XLEN-1:0] dmem_wdata,
    output logic             dmem_we,
    output logic             dmem_re,
    input  logic [`XLEN-1:0] dmem_rdata,
    input  logic             dready_n,
    input  logic             dbusy
);

    import cpu_pkg::*;

    // pipeline control
    logic               freeze;
    logic               hold_fetch;
    logic               squash_if_id;
    logic               squash_id_ex;
    logic               branch_taken;
    logic [`XLEN-1:0]   branch_target;

    // if/id
    logic [`XLEN-1:0]   id_instr;
    logic [`XLEN-1:0]   id_pc;
    logic               id_valid;
    logic [`RIDX_W-1:0] rs_a;
    logic [`RIDX_W-1:0] rs_b;

    // id/ex
    alu_op_t            ex_alu_op;
    mem_op_t            ex_mem_op;
    logic               ex_is_branch;
    logic               ex_is_jump;
    logic               ex_use_imm;
    logic [`XLEN-1:0]   ex_a;
    logic [`XLEN-1:0]   ex_b;
    logic [`XLEN-1:0]   ex_imm;
    logic [`XLEN-1:0]   ex_pc;
    logic [`RIDX_W-1:0] ex_rd;
    logic               ex_we;

    // ex/mem
    logic [`XLEN-1:0]   mem_alu;
    logic [`XLEN-1:0]   mem_store_data;
    logic [`RIDX_W-1:0] mem_rd;
    logic               mem_we;
    mem_op_t            mem_op;

    // mem/wb, also the regfile write port
    logic [`RIDX_W-1:0] wb_rd;
    logic               wb_we;
    logic [`XLEN-1:0]   wb_data;

    fetch_stage fetch_i (
        .clk, .rst, .freeze, .hold_fetch, .squash_if_id,
        .branch_taken, .branch_target,
        .imem_addr, .imem_rdata,
        .id_instr, .id_pc, .id_valid
    );

    decode_stage decode_i (
        .clk, .rst, .freeze, .hold_fetch, .squash_id_ex,
        .id_instr, .id_pc, .id_valid,
        .wb_we, .wb_rd, .wb_data,
        .rs_a, .rs_b,
        .ex_alu_op, .ex_mem_op, .ex_is_branch, .ex_is_jump, .ex_use_imm,
        .ex_a, .ex_b, .ex_imm, .ex_pc, .ex_rd, .ex_we
    );

    execute_stage execute_i (
        .clk, .rst, .freeze,
        .ex_alu_op, .ex_mem_op, .ex_is_branch, .ex_is_jump, .ex_use_imm,
        .ex_a, .ex_b, .ex_imm, .ex_pc, .ex_rd, .ex_we,
        .branch_taken, .branch_target,
        .mem_alu, .mem_store_data, .mem_rd, .mem_we, .mem_op
    );

    mem_stage mem_i (
        .clk, .rst, .freeze,
        .mem_alu, .mem_store_data, .mem_rd, .mem_we, .mem_op,
        .dmem_addr, .dmem_wdata, .dmem_we, .dmem_re, .dmem_rdata,
        .wb_rd, .wb_we, .wb_data
    );

    // stall / squash / freeze for every stage
    hazard_unit hazard_i (
        .clk, .rst,
        .rs_a, .rs_b,
        .ex_rd, .ex_we, .mem_rd, .mem_we, .wb_rd, .wb_we,
        .branch_taken, .mem_op, .iready_n, .dready_n, .dbusy,
        .freeze, .hold_fetch, .squash_if_id, .squash_id_ex
    );

endmodule

// File: design/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// datapath and address width
`define XLEN 32

// register file geometry
`define NREG   32
`define RIDX_W 5

// words per tb memory, instruction and data alike
`define MEM_WORDS 256

// first fetch address out of reset
`define RESET_PC 32'h0000_0000

`endif

// File: design/cpu_pkg.sv
package cpu_pkg;

    // major opcode, instr[31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_t;

    // r-type function field, instr[5:0]
    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_t;

    // bit 1 = read, bit 0 = write
    typedef enum logic [1:0] {
        MEM_NONE  = 2'b00,
        MEM_STORE = 2'b01,
        MEM_LOAD  = 2'b10
    } mem_op_t;

endpackage

// File: design/decode_stage.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module decode_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               freeze,
    input  logic               hold_fetch,
    input  logic               squash_id_ex,
    input  logic [`XLEN-1:0]   id_instr,
    input  logic [`XLEN-1:0]   id_pc,
    input  logic               id_valid,
    input  logic               wb_we,
    input  logic [`RIDX_W-1:0] wb_rd,
    input  logic [`XLEN-1:0]   wb_data,
    output logic [`RIDX_W-1:0] rs_a,
    output logic [`RIDX_W-1:0] rs_b,
    output cpu_pkg::alu_op_t   ex_alu_op,
    output cpu_pkg::mem_op_t   ex_mem_op,
    output logic               ex_is_branch,
    output logic               ex_is_jump,
    output logic               ex_use_imm,
    output logic [`XLEN-1:0]   ex_a,
    output logic [`XLEN-1:0]   ex_b,
    output logic [`XLEN-1:0]   ex_imm,
    output logic [`XLEN-1:0]   ex_pc,
    output logic [`RIDX_W-1:0] ex_rd,
    output logic               ex_we
);

    import cpu_pkg::*;

    opcode_t            opcode;
    funct_t             funct;
    logic [`RIDX_W-1:0] f_rs;
    logic [`RIDX_W-1:0] f_rt;
    logic [`RIDX_W-1:0] f_rd;

    alu_op_t            d_alu_op;
    mem_op_t            d_mem_op;
    logic               d_is_branch;
    logic               d_is_jump;
    logic               d_use_imm;
    logic               d_we;
    logic               d_use_a;     // instr really reads rs
    logic               d_use_b;     // instr really reads rt
    logic [`RIDX_W-1:0] d_rd;
    logic [`XLEN-1:0]   d_imm;
    logic               id_bubble;

    logic [`XLEN-1:0]   regs [`NREG];
    logic [`XLEN-1:0]   rd_a;
    logic [`XLEN-1:0]   rd_b;

    assign opcode = opcode_t'(id_instr[31:26]);
    assign funct  = funct_t'(id_instr[5:0]);
    assign f_rs   = id_instr[25:21];
    assign f_rt   = id_instr[20:16];
    assign f_rd   = id_instr[15:11];

    always_comb begin
        d_alu_op    = ALU_ADD;
        d_mem_op    = MEM_NONE;
        d_is_branch = 1'b0;
        d_is_jump   = 1'b0;
        d_use_imm   = 1'b0;
        d_we        = 1'b0;
        d_use_a     = 1'b0;
        d_use_b     = 1'b0;
        d_rd        = f_rt;                                       // i-type dest
        d_imm       = {{(`XLEN-16){id_instr[15]}}, id_instr[15:0]}; // sign ext
        case (opcode)
            OP_RTYPE: begin
                d_use_a = 1'b1;
                d_use_b = 1'b1;
                d_rd    = f_rd;
                d_we    = 1'b1;
                case (funct)
                    FN_ADD:  d_alu_op = ALU_ADD;
                    FN_SUB:  d_alu_op = ALU_SUB;
                    FN_AND:  d_alu_op = ALU_AND;
                    FN_OR:   d_alu_op = ALU_OR;
                    FN_SLT:  d_alu_op = ALU_SLT;
                    default: d_we     = 1'b0;   // unknown funct runs as nop
                endcase
            end
            OP_ADDI: begin
                d_use_a   = 1'b1;
                d_use_imm = 1'b1;
                d_we      = 1'b1;
            end
            OP_LW: begin
                d_use_a   = 1'b1;
                d_use_imm = 1'b1;
                d_we      = 1'b1;
                d_mem_op  = MEM_LOAD;
            end
            OP_SW: begin
                d_use_a   = 1'b1;
                d_use_b   = 1'b1;   // rt is the store data
                d_use_imm = 1'b1;
                d_mem_op  = MEM_STORE;
            end
            OP_BEQ: begin
                d_use_a     = 1'b1;
                d_use_b     = 1'b1;
                d_is_branch = 1'b1;
                d_alu_op    = ALU_SUB;
            end
            OP_J: begin
                d_is_jump = 1'b1;
                d_imm     = {{(`XLEN-26){1'b0}}, id_instr[25:0]};  // word index
            end
            default: ;
        endcase
    end

    // only live source fields go to the hazard check
    assign rs_a = (id_valid && d_use_a) ? f_rs : '0;
    assign rs_b = (id_valid && d_use_b) ? f_rt : '0;

    // register file, r0 hardwired, no write-through
    always_ff @(posedge clk) begin
        if (wb_we && wb_rd != '0)
            regs[wb_rd] <= wb_data;
    end

    assign rd_a = (f_rs == '0) ? '0 : regs[f_rs];
    assign rd_b = (f_rt == '0) ? '0 : regs[f_rt];

    assign id_bubble = !id_valid || hold_fetch || squash_id_ex;

    // id/ex control
    always_ff @(posedge clk) begin
        if (!rst) begin
            ex_mem_op    <= MEM_NONE;
            ex_is_branch <= 1'b0;
            ex_is_jump   <= 1'b0;
            ex_we        <= 1'b0;
        end else if (!freeze) begin
            ex_mem_op    <= id_bubble ? MEM_NONE : d_mem_op;
            ex_is_branch <= !id_bubble && d_is_branch;
            ex_is_jump   <= !id_bubble && d_is_jump;
            ex_we        <= !id_bubble && d_we;
        end
    end

    // id/ex payload
    always_ff @(posedge clk) begin
        if (!freeze) begin
            ex_alu_op  <= d_alu_op;
            ex_use_imm <= d_use_imm;
            ex_a       <= rd_a;
            ex_b       <= rd_b;
            ex_imm     <= d_imm;
            ex_pc      <= id_pc;
            ex_rd      <= d_rd;
        end
    end

endmodule

// File: design/execute_stage.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module execute_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               freeze,
    input  cpu_pkg::alu_op_t   ex_alu_op,
    input  cpu_pkg::mem_op_t   ex_mem_op,
    input  logic               ex_is_branch,
    input  logic               ex_is_jump,
    input  logic               ex_use_imm,
    input  logic [`XLEN-1:0]   ex_a,
    input  logic [`XLEN-1:0]   ex_b,
    input  logic [`XLEN-1:0]   ex_imm,
    input  logic [`XLEN-1:0]   ex_pc,
    input  logic [`RIDX_W-1:0] ex_rd,
    input  logic               ex_we,
    output logic               branch_taken,
    output logic [`XLEN-1:0]   branch_target,
    output logic [`XLEN-1:0]   mem_alu,
    output logic [`XLEN-1:0]   mem_store_data,
    output logic [`RIDX_W-1:0] mem_rd,
    output logic               mem_we,
    output cpu_pkg::mem_op_t   mem_op
);

    import cpu_pkg::*;

    logic [`XLEN-1:0] opnd_b;
    logic [`XLEN-1:0] alu_res;
    logic [`XLEN-1:0] pc_plus4;

    assign opnd_b   = ex_use_imm ? ex_imm : ex_b;
    assign pc_plus4 = ex_pc + `XLEN'd4;

    always_comb begin
        case (ex_alu_op)
            ALU_ADD: alu_res = ex_a + opnd_b;   // also lw/sw address
            ALU_SUB: alu_res = ex_a - opnd_b;
            ALU_AND: alu_res = ex_a & opnd_b;
            ALU_OR:  alu_res = ex_a | opnd_b;
            ALU_SLT: alu_res = {{(`XLEN-1){1'b0}}, $signed(ex_a) < $signed(opnd_b)};
            default: alu_res = '0;
        endcase
    end

    // beq compares raw register values, j is always taken
    assign branch_taken = ex_is_jump || (ex_is_branch && (ex_a == ex_b));

    // j keeps the upper pc bits, beq is pc+4 relative in words
    assign branch_target = ex_is_jump ? {pc_plus4[`XLEN-1:28], ex_imm[25:0], 2'b00}
                                      : pc_plus4 + {ex_imm[`XLEN-3:0], 2'b00};

    // ex/mem control
    // the branch itself is older than what it squashes, so it always moves on
    always_ff @(posedge clk) begin
        if (!rst) begin
            mem_we <= 1'b0;
            mem_op <= MEM_NONE;
        end else if (!freeze) begin
            mem_we <= ex_we;
            mem_op <= ex_mem_op;
        end
    end

    // ex/mem payload
    always_ff @(posedge clk) begin
        if (!freeze) begin
            mem_alu        <= alu_res;
            mem_store_data <= ex_b;
            mem_rd         <= ex_rd;
        end
    end

endmodule

// File: design/fetch_stage.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module fetch_stage (
    input  logic             clk,
    input  logic             rst,
    input  logic             freeze,
    input  logic             hold_fetch,
    input  logic             squash_if_id,
    input  logic             branch_taken,
    input  logic [`XLEN-1:0] branch_target,
    output logic [`XLEN-1:0] imem_addr,
    input  logic [`XLEN-1:0] imem_rdata,
    output logic [`XLEN-1:0] id_instr,
    output logic [`XLEN-1:0] id_pc,
    output logic             id_valid
);

    logic [`XLEN-1:0] pc;

    assign imem_addr = pc;   // request is the pc itself

    // pc, frozen by memory waits, held by raw hazards
    always_ff @(posedge clk) begin
        if (!rst) begin
            pc <= `RESET_PC;
        end else if (!freeze) begin
            if (branch_taken)
                pc <= branch_target;      // redirect beats a hazard hold
            else if (!hold_fetch)
                pc <= pc + `XLEN'd4;
        end
    end

    // if/id valid bit, squash makes a bubble
    always_ff @(posedge clk) begin
        if (!rst) begin
            id_valid <= 1'b0;
        end else if (!freeze) begin
            if (squash_if_id)
                id_valid <= 1'b0;
            else if (!hold_fetch)
                id_valid <= 1'b1;
        end
    end

    // fetched word only taken when not frozen (iready_n low)
    always_ff @(posedge clk) begin
        if (!freeze && !hold_fetch) begin
            id_instr <= imem_rdata;
            id_pc    <= pc;
        end
    end

endmodule

// File: design/hazard_unit.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module hazard_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic [`RIDX_W-1:0] rs_a,
    input  logic [`RIDX_W-1:0] rs_b,
    input  logic [`RIDX_W-1:0] ex_rd,
    input  logic               ex_we,
    input  logic [`RIDX_W-1:0] mem_rd,
    input  logic               mem_we,
    input  logic [`RIDX_W-1:0] wb_rd,
    input  logic               wb_we,
    input  logic               branch_taken,
    input  cpu_pkg::mem_op_t   mem_op,
    input  logic               iready_n,
    input  logic               dready_n,
    input  logic               dbusy,
    output logic               freeze,
    output logic               hold_fetch,
    output logic               squash_if_id,
    output logic               squash_id_ex
);

    logic hit_ex;
    logic hit_mem;
    logic hit_wb;
    logic mem_stall;
    logic store_hold;
    logic store_held;   // current store in mem already took its hold

    // raw match of one older stage against both decode sources
    function automatic logic raw_hit(input logic               we,
                                     input logic [`RIDX_W-1:0] rd,
                                     input logic [`RIDX_W-1:0] a,
                                     input logic [`RIDX_W-1:0] b);
        raw_hit = we && (rd != '0) && ((rd == a) || (rd == b));
    endfunction

    assign hit_ex  = raw_hit(ex_we, ex_rd, rs_a, rs_b);
    assign hit_mem = raw_hit(mem_we, mem_rd, rs_a, rs_b);
    assign hit_wb  = raw_hit(wb_we, wb_rd, rs_a, rs_b);  // regfile not write-through

    assign hold_fetch = hit_ex || hit_mem || hit_wb;     // id/ex fills with bubbles

    // taken branch or jump kills the two younger slots
    assign squash_if_id = branch_taken;
    assign squash_id_ex = branch_taken;

    assign mem_stall  = iready_n || (dready_n && mem_op[1]) || dbusy;
    assign store_hold = mem_op[0] && !store_held;        // first cycle of each store
    assign freeze     = mem_stall || store_hold;

    // held flag clears once the pipe advances and the store leaves mem
    always_ff @(posedge clk) begin
        if (!rst)
            store_held <= 1'b0;
        else if (!freeze)
            store_held <= 1'b0;
        else if (mem_op[0])
            store_held <= 1'b1;
    end

endmodule

// File: design/mem_stage.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module mem_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               freeze,
    input  logic [`XLEN-1:0]   mem_alu,
    input  logic [`XLEN-1:0]   mem_store_data,
    input  logic [`RIDX_W-1:0] mem_rd,
    input  logic               mem_we,
    input  cpu_pkg::mem_op_t   mem_op,
    output logic [`XLEN-1:0]   dmem_addr,
    output logic [`XLEN-1:0]   dmem_wdata,
    output logic               dmem_we,
    output logic               dmem_re,
    input  logic [`XLEN-1:0]   dmem_rdata,
    output logic [`RIDX_W-1:0] wb_rd,
    output logic               wb_we,
    output logic [`XLEN-1:0]   wb_data
);

    // request straight off ex/mem
    assign dmem_addr  = mem_alu;
    assign dmem_wdata = mem_store_data;
    assign dmem_we    = mem_op[0];     // stays up through the store hold
    assign dmem_re    = mem_op[1];

    // mem/wb control
    always_ff @(posedge clk) begin
        if (!rst)
            wb_we <= 1'b0;
        else if (!freeze)
            wb_we <= mem_we;
    end

    // write-back select, load word only valid once dready_n dropped
    always_ff @(posedge clk) begin
        if (!freeze) begin
            wb_rd   <= mem_rd;
            wb_data <= dmem_re ? dmem_rdata : mem_alu;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# build and run the cpu testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module tb_cpu -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

# the run counts as passed only if the pass line shows up
echo "$out" | grep -q "^SIMULATION PASSED$"

// File: tb/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// instruction-level model of the program in prog, result lands in exp_mem
function automatic void run_reference();
    logic [`XLEN-1:0]   r [`NREG];
    logic [`XLEN-1:0]   pc;
    logic [`XLEN-1:0]   nxt;
    logic [`XLEN-1:0]   ins;
    logic [`XLEN-1:0]   imm;
    logic [`XLEN-1:0]   ea;
    logic [5:0]         op;
    logic [`RIDX_W-1:0] rs;
    logic [`RIDX_W-1:0] rt;
    logic [`RIDX_W-1:0] rd;
    logic               done;
    int                 steps;
    for (int i = 0; i < `NREG; i++)
        r[i] = '0;
    for (int i = 0; i < `MEM_WORDS; i++)
        exp_mem[i] = preload_word(i);
    pc    = `RESET_PC;
    done  = 1'b0;
    steps = 0;
    while (!done && steps < 10000) begin
        ins = prog[pc[9:2]];
        op  = ins[31:26];
        rs  = ins[25:21];
        rt  = ins[20:16];
        rd  = ins[15:11];
        imm = {{16{ins[15]}}, ins[15:0]};
        ea  = r[rs] + imm;
        nxt = pc + 4;
        case (op)
            OP_RTYPE: begin
                case (ins[5:0])
                    FN_ADD: r[rd] = r[rs] + r[rt];
                    FN_SUB: r[rd] = r[rs] - r[rt];
                    FN_AND: r[rd] = r[rs] & r[rt];
                    FN_OR:  r[rd] = r[rs] | r[rt];
                    FN_SLT: r[rd] = ($signed(r[rs]) < $signed(r[rt])) ? 1 : 0;
                    default: ;                          // treated as nop
                endcase
            end
            OP_ADDI: r[rt] = ea;
            OP_LW:   r[rt] = exp_mem[ea[9:2]];
            OP_SW:   exp_mem[ea[9:2]] = r[rt];
            OP_BEQ:  if (r[rs] == r[rt]) nxt = pc + 4 + (imm << 2);
            OP_J: begin
                nxt  = {nxt[31:28], ins[25:0], 2'b00};
                done = (nxt == pc);                     // self jump ends the program
            end
            default: ;
        endcase
        r[0]  = '0;                                     // r0 stays zero
        pc    = nxt;
        steps = steps + 1;
    end
endfunction

`endif

// File: tb/tb_cpu.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module tb_cpu;

    import cpu_pkg::*;

    localparam int RUN_CYCLES   = 2000;                 // per run, two runs
    localparam int RESET_CYCLES = 10;
    localparam int WDOG_CYCLES  = 2 * (RUN_CYCLES + RESET_CYCLES) + 980;
    localparam int LAST_PC      = 44 * 4;               // self jump slot
    localparam int REG_BASE     = 32'h200;              // register dump area

    logic             clk;
    logic             rst;
    logic [`XLEN-1:0] imem_addr;
    logic [`XLEN-1:0] imem_rdata;
    logic             iready_n;
    logic [`XLEN-1:0] dmem_addr;
    logic [`XLEN-1:0] dmem_wdata;
    logic             dmem_we;
    logic             dmem_re;
    logic [`XLEN-1:0] dmem_rdata;
    logic             dready_n;
    logic             dbusy;

    logic [`XLEN-1:0] prog [`MEM_WORDS];
    logic [`XLEN-1:0] dmem [`MEM_WORDS];
    logic [`XLEN-1:0] exp_mem [`MEM_WORDS];
    logic [`XLEN-1:0] first_img [`MEM_WORDS];
    logic [31:0]      lcg_state;
    logic             random_waits;
    logic             load_mem;
    int               errors;

    cpu_core dut_i (.*);

    function automatic logic [31:0] preload_word(input int i);
        return i * 32'h9e37_79b9 + 32'h1234_5678;       // every address bit matters
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] r_type(input funct_t fn, input int rd, rs, rt);
        return {OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    function automatic logic [31:0] i_type(input opcode_t op, input int rt, rs, imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    `include "tb_ref_model.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // instruction side answers straight from the array
    assign imem_rdata = prog[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    // wait signals, each low roughly 3 cycles in 4
    always @(posedge clk) begin
        #1;
        lcg_state = lcg_next(lcg_state);
        iready_n  = random_waits && (lcg_state[31:30] == 2'b00);
        dready_n  = random_waits && (lcg_state[29:28] == 2'b00);
        dbusy     = random_waits && (lcg_state[27:26] == 2'b00);
    end

    // data side, preload on request, else write when not busy
    always @(posedge clk) begin
        if (load_mem) begin
            for (int i = 0; i < `MEM_WORDS; i++)
                dmem[i] <= preload_word(i);
        end else if (dmem_we && !dbusy) begin
            dmem[dmem_addr[9:2]] <= dmem_wdata;
        end
    end

    task automatic build_program();
        for (int i = 0; i < `MEM_WORDS; i++)
            prog[i] = '0;                               // nop fill
        prog[0]  = i_type(OP_ADDI, 1, 0, 5);
        prog[1]  = i_type(OP_ADDI, 2, 1, 7);            // distance 1
        prog[2]  = r_type(FN_ADD, 3, 1, 2);             // distances 2 and 1
        prog[3]  = r_type(FN_SUB, 4, 3, 1);
        prog[4]  = i_type(OP_ADDI, 0, 0, 9);            // r0 write
        prog[5]  = r_type(FN_AND, 5, 3, 2);             // distance 3 on r3
        prog[6]  = r_type(FN_OR, 6, 4, 5);
        prog[7]  = r_type(FN_SLT, 7, 1, 2);
        prog[8]  = r_type(FN_SLT, 8, 2, 1);
        prog[9]  = i_type(OP_LW, 9, 0, 'h10);
        prog[10] = r_type(FN_ADD, 10, 9, 1);            // load use
        prog[11] = i_type(OP_SW, 10, 0, 'h14);
        prog[12] = i_type(OP_LW, 11, 0, 'h14);          // read back the store
        prog[13] = r_type(FN_SUB, 12, 11, 9);
        prog[14] = i_type(OP_BEQ, 2, 1, 1);             // not taken
        prog[15] = i_type(OP_ADDI, 13, 0, 'h33);
        prog[16] = i_type(OP_BEQ, 1, 1, 2);             // taken, skips two markers
        prog[17] = i_type(OP_SW, 1, 0, 'h20);
        prog[18] = i_type(OP_SW, 1, 0, 'h24);
        prog[19] = i_type(OP_ADDI, 14, 0, -2);
        prog[20] = {OP_J, 26'd23};
        prog[21] = i_type(OP_SW, 1, 0, 'h28);           // marker
        prog[22] = i_type(OP_ADDI, 14, 0, 1);
        prog[23] = i_type(OP_SW, 2, 0, 'h18);           // neighbour of word 5
        prog[24] = i_type(OP_ADDI, 15, 0, 'h100);
        prog[25] = i_type(OP_SW, 3, 15, 0);
        prog[26] = i_type(OP_LW, 16, 15, 0);
        for (int i = 0; i <= 16; i++)
            prog[27 + i] = i_type(OP_SW, i, 0, REG_BASE + 4 * i);  // register dump
        prog[44] = {OP_J, 26'd44};
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        rst      = 1'b0;
        load_mem = 1'b1;
        @(posedge clk);
        #1;
        load_mem = 1'b0;
        for (int c = 1; c < RESET_CYCLES; c++) begin
            @(negedge clk);
            if (dmem_we || dmem_re || imem_addr != `RESET_PC) begin
                $display("reset check: memory request active or pc not at reset value");
                errors++;
            end
            @(posedge clk);
        end
        #1;
        rst = 1'b1;
        @(negedge clk);                                 // first edge after release
        if (dmem_we || dmem_re || imem_addr != `RESET_PC) begin
            $display("reset check: request raised or pc moved right after reset release");
            errors++;
        end
    endtask

    task automatic run_program();
        repeat (RUN_CYCLES) @(posedge clk);
        @(negedge clk);
        if (imem_addr < LAST_PC || imem_addr > LAST_PC + 8) begin
            $display("program did not settle in its final jump, pc %h", imem_addr);
            errors++;
        end
    endtask

    task automatic compare_image(input logic against_first);
        logic [`XLEN-1:0] want;
        for (int i = 0; i < `MEM_WORDS; i++) begin
            want = against_first ? first_img[i] : exp_mem[i];
            if (dmem[i] !== want) begin
                $display("[ERROR] %0t addr %h expected %h actual %h", $time, i * 4,
                         want, dmem[i]);
                errors++;
            end
        end
    endtask

    initial begin
        repeat (WDOG_CYCLES) @(posedge clk);
        $display("timeout: run still going after %0d cycles", WDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        rst          = 1'b0;
        iready_n     = 1'b0;
        dready_n     = 1'b0;
        dbusy        = 1'b0;
        load_mem     = 1'b0;
        random_waits = 1'b1;
        lcg_state    = 32'hcda8_77d6;
        errors       = 0;
        build_program();
        run_reference();
        apply_reset();                                  // run with random waits
        run_program();
        compare_image(1'b0);
        for (int i = 0; i < `MEM_WORDS; i++)
            first_img[i] = dmem[i];
        random_waits = 1'b0;                            // second run, no waits
        apply_reset();
        run_program();
        compare_image(1'b0);
        compare_image(1'b1);
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule
